//--- tri_inv_top.f
+incdir+.
tri_inv_pkg.sv
cplx_recip.sv
cplx_dot.sv
cplx_mul.sv
tri_inv_ctrl.sv
tri_inv_top.sv
tb_clk_gen.sv
tb_tri_inv.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass or fail from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tri_inv -f tri_inv_top.f -o sim_tri_inv

./obj_dir/sim_tri_inv | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

//--- tb_tri_inv.sv
`timescale 1ns/1ps
`include "tri_inv_consts.svh"

module tb_tri_inv;

  localparam int N = `TRI_N;
  localparam int TIMEOUT = 4000;  // cycles per wait
  localparam longint PART_MAX = (64'sd1 <<< (`TRI_W - 1)) - 1;
  localparam longint PART_MIN = -PART_MAX - 1;

  logic clk_i;
  logic rst_ni;
  logic start_i = 1'b0;
  logic flush_i = 1'b0;
  logic out_ready_i = 1'b1;
  logic mat_row_valid_i = 1'b0;
  tri_inv_pkg::cplx_vec_t mat_row_i = '0;
  tri_inv_pkg::idx_t mat_row_addr_i = '0;
  tri_inv_pkg::idx_t mat_row_addr_o;
  logic mat_row_req_o;
  tri_inv_pkg::cplx_vec_t inv_col_o;
  tri_inv_pkg::idx_t inv_col_addr_o;
  logic inv_col_valid_o;
  logic busy_o;
  logic singular_o;

  tri_inv_pkg::cplx_vec_t mat [N];
  tri_inv_pkg::cplx_vec_t exp_col [N];
  logic exp_sing = 1'b0;
  logic [15:0] lfsr_q = 16'd2;
  bit rand_ready = 1'b0;
  bit stall_out = 1'b0;  // forces out_ready_i low
  int cols_seen = 0;
  int total_cols = 0;
  int mismatches = 0;
  int failures = 0;
  int srv_phase = 0;  // 0 idle, 1 answering, 2 answered
  int srv_cnt = 0;
  bit srv_wrong = 1'b0;
  bit hold_q = 1'b0;
  bit last_taken = 1'b0;
  tri_inv_pkg::cplx_vec_t held_col;
  tri_inv_pkg::idx_t held_addr;

  tb_clk_gen clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  tri_inv_top UUT (.*);

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[14:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [`TRI_W-1:0] clamp_part(input longint v);
    if (v > PART_MAX) return PART_MAX[`TRI_W-1:0];
    if (v < PART_MIN) return PART_MIN[`TRI_W-1:0];
    return v[`TRI_W-1:0];
  endfunction

  function automatic tri_inv_pkg::cplx_t ref_recip(input tri_inv_pkg::cplx_t x, output logic sing);
    longint a;
    longint b;
    longint den;
    tri_inv_pkg::cplx_t r;
    a = $signed(x.re);
    b = $signed(x.im);
    den = a * a + b * b;
    r = '0;
    sing = (den == 0);
    if (!sing) begin
      r.re = clamp_part((a <<< (2 * `TRI_FRAC)) / den);  // truncates toward zero
      r.im = clamp_part((-b <<< (2 * `TRI_FRAC)) / den);
    end
    return r;
  endfunction

  function automatic tri_inv_pkg::cplx_t ref_dot(input tri_inv_pkg::cplx_vec_t row,
                                                 input tri_inv_pkg::cplx_vec_t col,
                                                 input int lo, input int hi);
    longint sr;
    longint si;
    tri_inv_pkg::cplx_t r;
    sr = 0;
    si = 0;
    for (int k = lo; k <= hi; k++) begin
      sr = sr + longint'($signed(row[k].re)) * $signed(col[k].re)
              - longint'($signed(row[k].im)) * $signed(col[k].im);
      si = si + longint'($signed(row[k].re)) * $signed(col[k].im)
              + longint'($signed(row[k].im)) * $signed(col[k].re);
    end
    r.re = clamp_part(sr >>> `TRI_FRAC);
    r.im = clamp_part(si >>> `TRI_FRAC);
    return r;
  endfunction

  function automatic tri_inv_pkg::cplx_t ref_mul(input tri_inv_pkg::cplx_t d,
                                                 input tri_inv_pkg::cplx_t x);
    longint pr;
    longint pi;
    tri_inv_pkg::cplx_t r;
    pr = -(longint'($signed(d.re)) * $signed(x.re) - longint'($signed(d.im)) * $signed(x.im));
    pi = -(longint'($signed(d.re)) * $signed(x.im) + longint'($signed(d.im)) * $signed(x.re));
    r.re = clamp_part(pr >>> `TRI_FRAC);
    r.im = clamp_part(pi >>> `TRI_FRAC);
    return r;
  endfunction

  // whole inverse one column at a time
  function automatic void compute_reference();
    tri_inv_pkg::cplx_vec_t diag;
    tri_inv_pkg::cplx_vec_t col;
    logic s;
    exp_sing = 1'b0;
    for (int i = 0; i < N; i++) begin
      diag[i] = ref_recip(mat[i][i], s);
      exp_sing = exp_sing | s;
    end
    for (int j = 0; j < N; j++) begin
      col = '0;
      col[j] = diag[j];
      for (int i = j + 1; i < N; i++) begin
        col[i] = ref_mul(ref_dot(mat[i], col, j, i - 1), diag[i]);
      end
      exp_col[j] = col;
    end
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    $display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
    mismatches++;
  endtask

  task automatic report_failure(input string what);
    $display("%0t: %s", $time, what);
    failures++;
  endtask

  task automatic load_identity();
    for (int i = 0; i < N; i++) begin
      mat[i] = '0;
      mat[i][i].re = `TRI_W'(1 << `TRI_FRAC);
    end
  endtask

  // zero_row is the row with a cleared diagonal or -1 for none
  task automatic load_random(input int zero_row);
    tri_inv_pkg::cplx_t e;
    logic [15:0] v;
    for (int i = 0; i < N; i++) begin
      mat[i] = '0;
      for (int k = 0; k < i; k++) begin
        v = take_bits(14);
        e.re = {{2{v[13]}}, v[13:0]};
        v = take_bits(14);
        e.im = {{2{v[13]}}, v[13:0]};
        mat[i][k] = e;
      end
      v = take_bits(12);
      e.re = 16'(2048 + v[10:0]);  // magnitude 0.5 to 1
      if (v[11]) e.re = -e.re;
      v = take_bits(12);
      e.im = {{4{v[11]}}, v[11:0]};
      if (i == zero_row) e = '0;
      mat[i][i] = e;
    end
  endtask

  task automatic pulse_start();
    @(posedge clk_i);
    #1;
    start_i = 1'b1;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;
    assert (busy_o === 1'b1) else report_failure("busy_o did not rise after start_i");
  endtask

  task automatic run_matrix(input bit random_ready);
    int t;
    compute_reference();
    rand_ready = random_ready;
    cols_seen = 0;
    pulse_start();
    t = 0;
    while (cols_seen < N && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    assert (cols_seen == N) else report_failure("timeout waiting for the inverse columns");
    @(negedge clk_i);
    assert (singular_o === exp_sing) else report_mismatch("singular_o", singular_o, exp_sing);
    rand_ready = 1'b0;
  endtask

  task automatic flush_mid_run();
    int t;
    load_random(-1);
    compute_reference();
    rand_ready = 1'b1;
    cols_seen = 0;
    pulse_start();
    t = 0;
    while (cols_seen < 1 && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    assert (cols_seen >= 1) else report_failure("timeout waiting for a column before flush");
    stall_out = 1'b1;  // hold the next column
    @(negedge clk_i);
    t = 0;
    while (!(inv_col_valid_o && !out_ready_i) && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    assert (inv_col_valid_o && !out_ready_i)
      else report_failure("timeout waiting for a held column before flush");
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    @(negedge clk_i);
    assert (!busy_o && !inv_col_valid_o)
      else report_failure("busy_o or inv_col_valid_o still high after flush");
    stall_out = 1'b0;
    rand_ready = 1'b0;
  endtask

  task automatic check_column();
    assert (cols_seen < N) else report_failure("column offered after the last one");
    if (cols_seen < N) begin
      assert (inv_col_addr_o === tri_inv_pkg::idx_t'(cols_seen))
        else report_mismatch("inv_col_addr_o", inv_col_addr_o, cols_seen);
      assert (inv_col_o === exp_col[cols_seen])
        else report_mismatch("inv_col_o", inv_col_o, exp_col[cols_seen]);
      last_taken = (cols_seen == N - 1);
      cols_seen++;
      total_cols++;
    end
  endtask

  // row server and ready driver 1 ns after each edge
  always @(posedge clk_i) begin
    #1;
    if (stall_out) begin
      out_ready_i = 1'b0;
    end else begin
      out_ready_i = rand_ready ? (take_bits(1) != 0) : 1'b1;
    end
    mat_row_valid_i = 1'b0;
    if (!mat_row_req_o) begin
      srv_phase = 0;
    end else if (srv_phase == 0) begin
      srv_phase = 1;
      srv_cnt = int'(take_bits(2));  // 0 to 3 cycles
      srv_wrong = (take_bits(2) == 0);
    end
    if (srv_phase == 1) begin
      if (srv_cnt > 0) begin
        srv_cnt--;
      end else begin
        mat_row_addr_i = srv_wrong ? mat_row_addr_o + 1'b1 : mat_row_addr_o;
        mat_row_i = mat[mat_row_addr_i];
        mat_row_valid_i = 1'b1;
        if (srv_wrong) srv_wrong = 1'b0;
        else srv_phase = 2;
      end
    end
  end

  // compare at mid cycle where outputs are settled
  always @(negedge clk_i) begin
    if (last_taken) begin
      assert (!busy_o) else report_failure("busy_o still high after the last column");
    end
    last_taken = 1'b0;
    if (hold_q) begin
      assert (inv_col_valid_o) else report_failure("inv_col_valid_o dropped before transfer");
      assert (inv_col_o === held_col) else report_mismatch("inv_col_o", inv_col_o, held_col);
      assert (inv_col_addr_o === held_addr)
        else report_mismatch("inv_col_addr_o", inv_col_addr_o, held_addr);
    end
    if (inv_col_valid_o && !out_ready_i) begin
      assert (!mat_row_req_o) else report_failure("row request while a column waits");
    end
    hold_q = inv_col_valid_o && !out_ready_i && !flush_i;
    held_col = inv_col_o;
    held_addr = inv_col_addr_o;
    if (inv_col_valid_o && out_ready_i && !flush_i) begin
      check_column();
    end
  end

  initial begin
    int t;
    t = 0;
    while (rst_ni !== 1'b1 && t < 100) begin
      @(posedge clk_i);
      t++;
    end
    assert (rst_ni === 1'b1) else report_failure("reset was never released");
    @(negedge clk_i);
    assert (!busy_o && !inv_col_valid_o && !mat_row_req_o && !singular_o)
      else report_failure("outputs not low after reset");
    load_identity();
    run_matrix(1'b0);
    for (int m = 0; m < 5; m++) begin
      load_random(-1);
      run_matrix(1'b1);
    end
    load_random(2);  // zero diagonal in row 2
    run_matrix(1'b1);
    flush_mid_run();
    load_random(-1);
    run_matrix(1'b1);
    $display("columns checked: %0d, mismatches: %0d, other failures: %0d",
             total_cols, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_NS = 4;  // 8 ns period
  localparam int RST_CYCLES = 2;

  initial begin
    clk_o = 1'b0;
    forever #HALF_NS clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

//--- tri_inv_top.sv
`timescale 1ns/1ps

module tri_inv_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  logic                   flush_i,
  input  tri_inv_pkg::cplx_vec_t mat_row_i,
  input  logic                   mat_row_valid_i,
  input  tri_inv_pkg::idx_t      mat_row_addr_i,
  output tri_inv_pkg::idx_t      mat_row_addr_o,
  output logic                   mat_row_req_o,
  output tri_inv_pkg::cplx_vec_t inv_col_o,
  output tri_inv_pkg::idx_t      inv_col_addr_o,
  output logic                   inv_col_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o,
  output logic                   singular_o
);

  tri_inv_pkg::cplx_t rcp_in;
  tri_inv_pkg::cplx_t rcp_res;
  logic rcp_valid;
  logic rcp_ready;
  logic rcp_sing;
  logic rcp_out_valid;

  tri_inv_pkg::cplx_vec_t dot_row;
  tri_inv_pkg::cplx_vec_t dot_col;
  tri_inv_pkg::idx_t dot_lo;
  tri_inv_pkg::idx_t dot_hi;
  tri_inv_pkg::cplx_t dot_res;
  logic dot_valid;
  logic dot_ready;
  logic dot_out_valid;

  tri_inv_pkg::cplx_t mul_a;
  tri_inv_pkg::cplx_t mul_b;
  tri_inv_pkg::cplx_t mul_res;
  logic mul_valid;
  logic mul_ready;
  logic mul_out_valid;

  tri_inv_ctrl u_ctrl (
    .clk_i, .rst_ni, .start_i, .flush_i, .out_ready_i,
    .mat_row_valid_i, .mat_row_i, .mat_row_addr_i,
    .mat_row_addr_o, .mat_row_req_o, .inv_col_valid_o, .busy_o, .singular_o,
    .inv_col_o, .inv_col_addr_o,
    .rcp_in_o(rcp_in), .rcp_valid_o(rcp_valid), .rcp_ready_i(rcp_ready),
    .rcp_res_i(rcp_res), .rcp_sing_i(rcp_sing), .rcp_out_valid_i(rcp_out_valid),
    .dot_row_o(dot_row), .dot_col_o(dot_col), .dot_lo_o(dot_lo), .dot_hi_o(dot_hi),
    .dot_valid_o(dot_valid), .dot_ready_i(dot_ready), .dot_out_valid_i(dot_out_valid),
    .dot_res_i(dot_res),
    .mul_a_o(mul_a), .mul_b_o(mul_b), .mul_valid_o(mul_valid), .mul_ready_i(mul_ready),
    .mul_out_valid_i(mul_out_valid), .mul_res_i(mul_res)
  );

  // results are always taken on arrival
  cplx_recip u_recip (
    .clk_i, .rst_ni, .flush_i,
    .in_i(rcp_in), .in_valid_i(rcp_valid), .in_ready_o(rcp_ready),
    .res_o(rcp_res), .sing_o(rcp_sing), .out_valid_o(rcp_out_valid), .out_ready_i(1'b1)
  );

  cplx_dot u_dot (
    .clk_i, .rst_ni, .flush_i,
    .row_i(dot_row), .col_i(dot_col), .lo_i(dot_lo), .hi_i(dot_hi),
    .in_valid_i(dot_valid), .in_ready_o(dot_ready),
    .res_o(dot_res), .out_valid_o(dot_out_valid), .out_ready_i(1'b1)
  );

  cplx_mul u_mul (
    .clk_i, .rst_ni, .flush_i,
    .a_i(mul_a), .b_i(mul_b), .in_valid_i(mul_valid), .in_ready_o(mul_ready),
    .res_o(mul_res), .out_valid_o(mul_out_valid), .out_ready_i(1'b1)
  );

endmodule

//--- tri_inv_ctrl.sv
`timescale 1ns/1ps
`include "tri_inv_consts.svh"

module tri_inv_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  logic                   flush_i,
  input  logic                   out_ready_i,
  input  logic                   mat_row_valid_i,
  input  tri_inv_pkg::cplx_vec_t mat_row_i,
  input  tri_inv_pkg::idx_t      mat_row_addr_i,
  output tri_inv_pkg::idx_t      mat_row_addr_o,
  output logic                   mat_row_req_o,
  output logic                   inv_col_valid_o,
  output logic                   busy_o,
  output logic                   singular_o,
  output tri_inv_pkg::cplx_vec_t inv_col_o,
  output tri_inv_pkg::idx_t      inv_col_addr_o,
  output tri_inv_pkg::cplx_t     rcp_in_o,
  output logic                   rcp_valid_o,
  input  logic                   rcp_ready_i,
  input  tri_inv_pkg::cplx_t     rcp_res_i,
  input  logic                   rcp_sing_i,
  input  logic                   rcp_out_valid_i,
  output tri_inv_pkg::cplx_vec_t dot_row_o,
  output tri_inv_pkg::cplx_vec_t dot_col_o,
  output tri_inv_pkg::idx_t      dot_lo_o,
  output tri_inv_pkg::idx_t      dot_hi_o,
  output logic                   dot_valid_o,
  input  logic                   dot_ready_i,
  input  logic                   dot_out_valid_i,
  input  tri_inv_pkg::cplx_t     dot_res_i,
  output tri_inv_pkg::cplx_t     mul_a_o,
  output tri_inv_pkg::cplx_t     mul_b_o,
  output logic                   mul_valid_o,
  input  logic                   mul_ready_i,
  input  logic                   mul_out_valid_i,
  input  tri_inv_pkg::cplx_t     mul_res_i
);

  localparam tri_inv_pkg::idx_t LAST = tri_inv_pkg::idx_t'(`TRI_N - 1);

  tri_inv_pkg::ctrl_state_e state_q;
  tri_inv_pkg::idx_t row_q;
  tri_inv_pkg::idx_t col_q;
  tri_inv_pkg::idx_t next_col;
  logic req_q;
  logic op_pend_q;  // row taken, operand not yet handed over
  logic mul_pend_q;
  logic sing_q;
  logic row_take;
  logic op_fire;
  tri_inv_pkg::cplx_vec_t row_buf_q;
  tri_inv_pkg::cplx_vec_t diag_q;  // diagonal reciprocals
  tri_inv_pkg::cplx_vec_t colv_q;
  tri_inv_pkg::cplx_t mul_a_q;

  assign row_take = req_q && mat_row_valid_i && (mat_row_addr_i == row_q);
  assign op_fire = (rcp_valid_o && rcp_ready_i) || (dot_valid_o && dot_ready_i);
  assign next_col = col_q + 1'b1;

  assign mat_row_addr_o = row_q;
  assign mat_row_req_o = req_q;
  assign inv_col_o = colv_q;
  assign inv_col_addr_o = col_q;
  assign inv_col_valid_o = (state_q == tri_inv_pkg::EMIT);
  assign busy_o = (state_q != tri_inv_pkg::IDLE);
  assign singular_o = sing_q;

  assign rcp_in_o = row_buf_q[row_q];  // diagonal element of the row
  assign rcp_valid_o = op_pend_q && (state_q == tri_inv_pkg::DIAG);
  assign dot_row_o = row_buf_q;
  assign dot_col_o = colv_q;
  assign dot_lo_o = col_q;
  assign dot_hi_o = row_q - 1'b1;
  assign dot_valid_o = op_pend_q && (state_q == tri_inv_pkg::COLUMN);
  assign mul_a_o = mul_a_q;
  assign mul_b_o = diag_q[row_q];
  assign mul_valid_o = mul_pend_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      state_q <= tri_inv_pkg::IDLE;
      row_q <= '0;
      col_q <= '0;
      req_q <= 1'b0;
      op_pend_q <= 1'b0;
      mul_pend_q <= 1'b0;
    end else begin
      if (row_take) begin
        req_q <= 1'b0;
        op_pend_q <= 1'b1;
      end
      if (op_fire) begin
        op_pend_q <= 1'b0;
      end
      if (dot_out_valid_i) begin
        mul_pend_q <= 1'b1;
      end else if (mul_valid_o && mul_ready_i) begin
        mul_pend_q <= 1'b0;
      end
      case (state_q)
        tri_inv_pkg::IDLE: begin
          if (start_i) begin
            state_q <= tri_inv_pkg::DIAG;
            row_q <= '0;
            req_q <= 1'b1;
          end
        end
        tri_inv_pkg::DIAG: begin
          if (rcp_out_valid_i) begin
            req_q <= 1'b1;
            if (row_q == LAST) begin
              state_q <= tri_inv_pkg::COLUMN;  // column 0 starts at row 1
              col_q <= '0;
              row_q <= tri_inv_pkg::idx_t'(1);
            end else begin
              row_q <= row_q + 1'b1;
            end
          end
        end
        tri_inv_pkg::COLUMN: begin
          if (mul_out_valid_i) begin
            if (row_q == LAST) begin
              state_q <= tri_inv_pkg::EMIT;
            end else begin
              row_q <= row_q + 1'b1;
              req_q <= 1'b1;
            end
          end
        end
        default: begin
          if (out_ready_i) begin
            if (col_q == LAST) begin
              state_q <= tri_inv_pkg::IDLE;
            end else begin
              col_q <= next_col;
              if (next_col != LAST) begin  // last column has only its diagonal
                state_q <= tri_inv_pkg::COLUMN;
                row_q <= next_col + 1'b1;
                req_q <= 1'b1;
              end
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sing_q <= 1'b0;
    end else if (state_q == tri_inv_pkg::IDLE && start_i) begin
      sing_q <= 1'b0;
    end else if (rcp_out_valid_i && rcp_sing_i) begin
      sing_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (row_take) begin
      row_buf_q <= mat_row_i;
    end
    if (dot_out_valid_i) begin
      mul_a_q <= dot_res_i;
    end
    if (rcp_out_valid_i) begin
      diag_q[row_q] <= rcp_res_i;
    end
    if (state_q == tri_inv_pkg::DIAG && rcp_out_valid_i && row_q == LAST) begin
      colv_q <= '0;
      colv_q[0] <= diag_q[0];
    end
    if (mul_out_valid_i) begin
      colv_q[row_q] <= mul_res_i;
    end
    if (state_q == tri_inv_pkg::EMIT && out_ready_i && col_q != LAST) begin
      colv_q <= '0;  // seed next column with its reciprocal
      colv_q[next_col] <= diag_q[next_col];
    end
  end

endmodule

//--- cplx_mul.sv
`timescale 1ns/1ps

module cplx_mul (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  tri_inv_pkg::cplx_t a_i,
  input  tri_inv_pkg::cplx_t b_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  output tri_inv_pkg::cplx_t res_o,
  output logic               out_valid_o,
  input  logic               out_ready_i
);

  logic signed [tri_inv_pkg::ACC_W-1:0] p_re;
  logic signed [tri_inv_pkg::ACC_W-1:0] p_im;
  logic accept;

  // product of -a and b
  assign p_re = a_i.im * b_i.im - a_i.re * b_i.re;
  assign p_im = -(a_i.re * b_i.im + a_i.im * b_i.re);

  assign in_ready_o = !out_valid_o || out_ready_i;  // refill while draining
  assign accept = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      out_valid_o <= 1'b0;
    end else if (accept) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      res_o.re <= tri_inv_pkg::sat_shift(p_re);
      res_o.im <= tri_inv_pkg::sat_shift(p_im);
    end
  end

endmodule

//--- cplx_dot.sv
`timescale 1ns/1ps

module cplx_dot (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  tri_inv_pkg::cplx_vec_t row_i,
  input  tri_inv_pkg::cplx_vec_t col_i,
  input  tri_inv_pkg::idx_t      lo_i,
  input  tri_inv_pkg::idx_t      hi_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output tri_inv_pkg::cplx_t     res_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i
);

  tri_inv_pkg::cplx_vec_t row_q;
  tri_inv_pkg::cplx_vec_t col_q;
  tri_inv_pkg::idx_t k_q;
  tri_inv_pkg::idx_t hi_q;
  logic busy_q;
  logic done_q;
  logic signed [tri_inv_pkg::ACC_W-1:0] acc_re_q;
  logic signed [tri_inv_pkg::ACC_W-1:0] acc_im_q;
  logic signed [tri_inv_pkg::ACC_W-1:0] prod_re;
  logic signed [tri_inv_pkg::ACC_W-1:0] prod_im;
  tri_inv_pkg::cplx_t a;
  tri_inv_pkg::cplx_t b;

  assign a = row_q[k_q];
  assign b = col_q[k_q];
  assign prod_re = a.re * b.re - a.im * b.im;  // full precision, no rounding yet
  assign prod_im = a.re * b.im + a.im * b.re;

  assign in_ready_o = !busy_q && !done_q;
  assign out_valid_o = done_q;
  assign res_o.re = tri_inv_pkg::sat_shift(acc_re_q);
  assign res_o.im = tri_inv_pkg::sat_shift(acc_im_q);

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (in_valid_i && in_ready_o) begin
        busy_q <= 1'b1;
      end else if (busy_q && k_q == hi_q) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      if (done_q && out_ready_i) begin
        done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      row_q <= row_i;
      col_q <= col_i;
      k_q <= lo_i;
      hi_q <= hi_i;
      acc_re_q <= '0;
      acc_im_q <= '0;
    end else if (busy_q) begin
      acc_re_q <= acc_re_q + prod_re;  // one term per cycle
      acc_im_q <= acc_im_q + prod_im;
      k_q <= k_q + 1'b1;
    end
  end

endmodule

//--- cplx_recip.sv
`timescale 1ns/1ps
`include "tri_inv_consts.svh"

module cplx_recip (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  tri_inv_pkg::cplx_t in_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  output tri_inv_pkg::cplx_t res_o,
  output logic               sing_o,
  output logic               out_valid_o,
  input  logic               out_ready_i
);

  localparam int NUM_W = 2 * `TRI_FRAC + `TRI_W;  // one quotient bit per cycle
  localparam int DEN_W = 2 * `TRI_W;
  localparam logic [NUM_W-1:0] MAG_MAX = 1 << (`TRI_W - 1);

  tri_inv_pkg::div_state_e state_q;
  tri_inv_pkg::cplx_t op_q;
  logic [`TRI_W-1:0] abs_re;
  logic [`TRI_W-1:0] abs_im;
  logic [DEN_W-1:0] den_q;
  logic [DEN_W-1:0] rem_re_q;
  logic [DEN_W-1:0] rem_im_q;
  logic [NUM_W-1:0] q_re_q;
  logic [NUM_W-1:0] q_im_q;
  logic neg_re_q;
  logic neg_im_q;
  logic zero_q;
  logic [$clog2(NUM_W)-1:0] cnt_q;

  // restoring step: numerator bits leave at the top, quotient bits enter at the bottom
  function automatic logic [DEN_W+NUM_W-1:0] div_step(input logic [DEN_W-1:0] rem,
                                                      input logic [NUM_W-1:0] q,
                                                      input logic [DEN_W-1:0] den);
    logic [DEN_W:0] sh;
    sh = {rem, q[NUM_W-1]};
    if (sh >= {1'b0, den}) begin
      sh = sh - {1'b0, den};
      return {sh[DEN_W-1:0], q[NUM_W-2:0], 1'b1};
    end
    return {sh[DEN_W-1:0], q[NUM_W-2:0], 1'b0};
  endfunction

  function automatic logic [`TRI_W-1:0] sat_mag(input logic neg, input logic [NUM_W-1:0] mag);
    if (neg) begin
      return (mag > MAG_MAX) ? {1'b1, {(`TRI_W-1){1'b0}}} : ~mag[`TRI_W-1:0] + 1'b1;
    end
    return (mag >= MAG_MAX) ? {1'b0, {(`TRI_W-1){1'b1}}} : mag[`TRI_W-1:0];
  endfunction

  assign abs_re = op_q.re[`TRI_W-1] ? ~op_q.re + 1'b1 : op_q.re;
  assign abs_im = op_q.im[`TRI_W-1] ? ~op_q.im + 1'b1 : op_q.im;

  assign in_ready_o = (state_q == tri_inv_pkg::D_IDLE);
  assign out_valid_o = (state_q == tri_inv_pkg::D_DONE);
  assign sing_o = zero_q;
  assign res_o.re = zero_q ? '0 : sat_mag(neg_re_q, q_re_q);
  assign res_o.im = zero_q ? '0 : sat_mag(neg_im_q, q_im_q);

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      state_q <= tri_inv_pkg::D_IDLE;
    end else begin
      case (state_q)
        tri_inv_pkg::D_IDLE: begin
          if (in_valid_i) begin
            state_q <= tri_inv_pkg::D_NORM;
          end
        end
        tri_inv_pkg::D_NORM: state_q <= tri_inv_pkg::D_DIV;
        tri_inv_pkg::D_DIV: begin
          if (cnt_q == '0) begin
            state_q <= tri_inv_pkg::D_DONE;
          end
        end
        default: begin
          if (out_ready_i) begin
            state_q <= tri_inv_pkg::D_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      op_q <= in_i;
    end
    if (state_q == tri_inv_pkg::D_NORM) begin
      den_q <= abs_re * abs_re + abs_im * abs_im;
      q_re_q <= {abs_re, {(2 * `TRI_FRAC){1'b0}}};
      q_im_q <= {abs_im, {(2 * `TRI_FRAC){1'b0}}};
      rem_re_q <= '0;
      rem_im_q <= '0;
      neg_re_q <= op_q.re[`TRI_W-1];
      neg_im_q <= ~op_q.im[`TRI_W-1];  // conjugate flips the sign
      zero_q <= (op_q.re == '0) && (op_q.im == '0);
      cnt_q <= ($clog2(NUM_W))'(NUM_W - 1);
    end
    if (state_q == tri_inv_pkg::D_DIV) begin
      {rem_re_q, q_re_q} <= div_step(rem_re_q, q_re_q, den_q);
      {rem_im_q, q_im_q} <= div_step(rem_im_q, q_im_q, den_q);
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

//--- tri_inv_pkg.sv
package tri_inv_pkg;
`include "tri_inv_consts.svh"

  localparam int ACC_W = 2 * `TRI_W + $clog2(`TRI_N) + 2;  // N full products summed
  localparam logic signed [ACC_W-1:0] SAT_MAX = (2 ** (`TRI_W - 1)) - 1;
  localparam logic signed [ACC_W-1:0] SAT_MIN = -(2 ** (`TRI_W - 1));

  typedef logic [$clog2(`TRI_N)-1:0] idx_t;

  typedef struct packed {
    logic signed [`TRI_W-1:0] im;
    logic signed [`TRI_W-1:0] re;  // real part in the low bits
  } cplx_t;

  typedef cplx_t [`TRI_N-1:0] cplx_vec_t;  // element 0 at the low end

  typedef enum logic [1:0] {IDLE, DIAG, COLUMN, EMIT} ctrl_state_e;

  typedef enum logic [1:0] {D_IDLE, D_NORM, D_DIV, D_DONE} div_state_e;

  // drop the fraction of a full product, then clamp to one part
  function automatic logic [`TRI_W-1:0] sat_shift(input logic signed [ACC_W-1:0] v);
    logic signed [ACC_W-1:0] s;
    s = v >>> `TRI_FRAC;
    if (s > SAT_MAX) begin
      return SAT_MAX[`TRI_W-1:0];
    end
    if (s < SAT_MIN) begin
      return SAT_MIN[`TRI_W-1:0];
    end
    return s[`TRI_W-1:0];
  endfunction

endpackage

//--- tri_inv_consts.svh
`ifndef TRI_INV_CONSTS_SVH
`define TRI_INV_CONSTS_SVH

// matrix order
`define TRI_N 4

// width of each real and imaginary part
`define TRI_W 16

// fraction bits of the fixed point format
`define TRI_FRAC 12

`endif
